// ==== fft_bins_pkg.sv ====
// Shared widths, bus addresses, window constants and bridge states
// for the sliding-window spectral bin accelerator
`default_nettype none

package fft_bins_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int SAMPLE_W = 16;
  // Eight 16-bit samples need three extra bits
  localparam int ACC_W    = 19;
  localparam int WORD_W   = 32;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic [WORD_W-1:0]          word_t;
  typedef logic [WORD_W-1:0]          addr_t;

  // ----------------------------------------
  // Window
  // ----------------------------------------
  localparam int WINDOW_LEN   = 8;
  localparam int WINDOW_SHIFT = 3;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam addr_t BASE_ADDR = 32'h3000_0000;
  localparam addr_t BIN_ADDR  = BASE_ADDR + 32'd4;

  // Bridge sequencing
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2,
    LOOP = 2'd3
  } bridge_state_t;

endpackage

`default_nettype wire

// ==== accel_link_if.sv ====
// Sample and result streams between the bus bridge and the bin engine
// The bridge pushes samples, the combiner returns packed bin words
`default_nettype none

interface accel_link_if;

  // Sample stream into both accumulators
  logic                  smp_val;
  logic                  smp_rdy;
  fft_bins_pkg::sample_t smp_data;

  // Packed bin word back to the bridge
  logic                  res_val;
  logic                  res_rdy;
  fft_bins_pkg::word_t   res_data;

  modport bridge (
    output smp_val,
    output smp_data,
    output res_rdy,
    input  smp_rdy,
    input  res_val,
    input  res_data
  );

  modport accum (
    input smp_val,
    input smp_data
  );

  modport combiner (
    output smp_rdy,
    output res_val,
    output res_data,
    input  res_rdy
  );

endinterface

`default_nettype wire

// ==== wb_stream_bridge.sv ====
// Wishbone slave in front of the bin engine
// Holds the loopback register and sequences sample writes and bin reads
`default_nettype none

module wb_stream_bridge (
  input  logic                clk,
  input  logic                reset,
  input  logic                wbs_stb_i,
  input  logic                wbs_cyc_i,
  input  logic                wbs_we_i,
  input  fft_bins_pkg::addr_t wbs_adr_i,
  input  fft_bins_pkg::word_t wbs_dat_i,
  output logic                wbs_ack_o,
  output fft_bins_pkg::word_t wbs_dat_o,
  accel_link_if.bridge        link
);

  fft_bins_pkg::bridge_state_t state;
  fft_bins_pkg::bridge_state_t next_state;

  fft_bins_pkg::word_t loopback_reg;
  logic                loopback_en;
  logic                rd_sel_bin;

  logic bus_req;
  logic is_write_loop;
  logic is_read_loop;
  logic is_write_bin;
  logic is_read_bin;

  // ----------------------------------------
  // Access decode
  // ----------------------------------------
  assign bus_req = wbs_stb_i && wbs_cyc_i;

  always_comb begin
    is_write_loop = bus_req && wbs_we_i && (wbs_adr_i == fft_bins_pkg::BASE_ADDR);
    is_read_loop  = bus_req && !wbs_we_i && (wbs_adr_i == fft_bins_pkg::BASE_ADDR);
    is_write_bin  = bus_req && wbs_we_i && (wbs_adr_i == fft_bins_pkg::BIN_ADDR);
    is_read_bin   = bus_req && !wbs_we_i && (wbs_adr_i == fft_bins_pkg::BIN_ADDR);
  end

  // Loopback register
  always_ff @(posedge clk) begin
    if (reset) begin
      loopback_reg <= '0;
    end else if (loopback_en) begin
      loopback_reg <= wbs_dat_i;
    end
  end

  // Sample is the low half of the written word
  assign link.smp_data = wbs_dat_i[fft_bins_pkg::SAMPLE_W-1:0];

  assign wbs_dat_o = rd_sel_bin ? link.res_data : loopback_reg;

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fft_bins_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state    = state;
    wbs_ack_o     = 1'b0;
    link.smp_val  = 1'b0;
    link.res_rdy  = 1'b0;
    loopback_en   = 1'b0;
    rd_sel_bin    = 1'b0;
    case (state)
      fft_bins_pkg::IDLE: begin
        // Sample write waits while the engine still holds a result
        if (is_write_bin && link.smp_rdy) begin
          link.smp_val = 1'b1;
          next_state   = fft_bins_pkg::BUSY;
        end else if (is_write_loop) begin
          wbs_ack_o   = 1'b1;
          loopback_en = 1'b1;
          next_state  = fft_bins_pkg::LOOP;
        end
      end
      fft_bins_pkg::BUSY: begin
        // Write completes once the packed bins are ready
        if (is_write_bin && link.res_val) begin
          wbs_ack_o  = 1'b1;
          next_state = fft_bins_pkg::DONE;
        end
      end
      fft_bins_pkg::DONE: begin
        rd_sel_bin = 1'b1;
        if (is_read_bin) begin
          wbs_ack_o    = 1'b1;
          link.res_rdy = 1'b1;
          next_state   = fft_bins_pkg::IDLE;
        end
      end
      fft_bins_pkg::LOOP: begin
        if (is_read_loop) begin
          wbs_ack_o  = 1'b1;
          next_state = fft_bins_pkg::IDLE;
        end
      end
      default: begin
        next_state = fft_bins_pkg::IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  ack_needs_request: assert property (
    @(posedge clk) disable iff (reset)
    wbs_ack_o |-> (wbs_stb_i && wbs_cyc_i)
  );

  // Accumulators capture on smp_val alone, so the combiner must be free
  sample_only_when_ready: assert property (
    @(posedge clk) disable iff (reset)
    link.smp_val |-> (link.smp_rdy && !link.res_val)
  );

endmodule

`default_nettype wire

// ==== dc_window_accum.sv ====
// DC bin over the last eight samples
// Keeps a sample history and a running sum updated per sample
`default_nettype none

module dc_window_accum (
  input  logic               clk,
  input  logic               reset,
  accel_link_if.accum        link,
  output logic               dc_val_o,
  output fft_bins_pkg::acc_t dc_sum_o
);

  // Entry 0 is the newest sample
  fft_bins_pkg::sample_t hist [fft_bins_pkg::WINDOW_LEN];

  fft_bins_pkg::acc_t new_smp;
  fft_bins_pkg::acc_t old_smp;

  // Widen both ends of the window to the sum width
  assign new_smp = fft_bins_pkg::acc_t'(link.smp_data);
  assign old_smp = fft_bins_pkg::acc_t'(hist[fft_bins_pkg::WINDOW_LEN-1]);

  // ----------------------------------------
  // History shift
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fft_bins_pkg::WINDOW_LEN; i++) begin
        hist[i] <= '0;
      end
    end else if (link.smp_val) begin
      hist[0] <= link.smp_data;
      for (int i = 1; i < fft_bins_pkg::WINDOW_LEN; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // Running sum, add the new sample and drop the oldest
  always_ff @(posedge clk) begin
    if (reset) begin
      dc_sum_o <= '0;
      dc_val_o <= 1'b0;
    end else begin
      dc_val_o <= link.smp_val;
      if (link.smp_val) begin
        dc_sum_o <= dc_sum_o + new_smp - old_smp;
      end
    end
  end

endmodule

`default_nettype wire

// ==== nyquist_window_accum.sv ====
// Nyquist bin over the last eight samples
// Alternating-sign sum with the newest sample taken positive
`default_nettype none

module nyquist_window_accum (
  input  logic               clk,
  input  logic               reset,
  accel_link_if.accum        link,
  output logic               nyq_val_o,
  output fft_bins_pkg::acc_t nyq_sum_o
);

  fft_bins_pkg::sample_t hist [fft_bins_pkg::WINDOW_LEN];

  fft_bins_pkg::acc_t new_smp;
  fft_bins_pkg::acc_t old_smp;

  assign new_smp = fft_bins_pkg::acc_t'(link.smp_data);
  assign old_smp = fft_bins_pkg::acc_t'(hist[fft_bins_pkg::WINDOW_LEN-1]);

  // ----------------------------------------
  // History shift
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fft_bins_pkg::WINDOW_LEN; i++) begin
        hist[i] <= '0;
      end
    end else if (link.smp_val) begin
      hist[0] <= link.smp_data;
      for (int i = 1; i < fft_bins_pkg::WINDOW_LEN; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // ----------------------------------------
  // Alternating sum
  // ----------------------------------------
  // Every sample already in the window flips sign when a new one
  // arrives, so negate the old sum. The leaving sample had a minus
  // sign and turns positive after the flip, hence it is subtracted
  always_ff @(posedge clk) begin
    if (reset) begin
      nyq_sum_o <= '0;
      nyq_val_o <= 1'b0;
    end else begin
      nyq_val_o <= link.smp_val;
      if (link.smp_val) begin
        nyq_sum_o <= new_smp - nyq_sum_o - old_smp;
      end
    end
  end

endmodule

`default_nettype wire

// ==== bin_combiner.sv ====
// Scales the DC and Nyquist bins and packs them into one bus word
// The word is held until the bridge reads it
`default_nettype none

module bin_combiner (
  input  logic               clk,
  input  logic               reset,
  input  logic               dc_val_i,
  input  fft_bins_pkg::acc_t dc_sum_i,
  input  logic               nyq_val_i,
  input  fft_bins_pkg::acc_t nyq_sum_i,
  accel_link_if.combiner     link
);

  logic               capture;
  fft_bins_pkg::acc_t dc_scaled;
  fft_bins_pkg::acc_t nyq_scaled;

  assign capture = dc_val_i && nyq_val_i;

  // Arithmetic shift divides by the window length, rounding down
  assign dc_scaled  = dc_sum_i >>> fft_bins_pkg::WINDOW_SHIFT;
  assign nyq_scaled = nyq_sum_i >>> fft_bins_pkg::WINDOW_SHIFT;

  // New samples only while no result is pending
  assign link.smp_rdy = !link.res_val;

  // ----------------------------------------
  // Result hold
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      link.res_val <= 1'b0;
    end else if (capture) begin
      link.res_val <= 1'b1;
    end else if (link.res_rdy) begin
      link.res_val <= 1'b0;
    end
  end

  // DC in the upper half, Nyquist in the lower half
  always_ff @(posedge clk) begin
    if (capture) begin
      link.res_data <= {dc_scaled[fft_bins_pkg::SAMPLE_W-1:0],
                        nyq_scaled[fft_bins_pkg::SAMPLE_W-1:0]};
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  bins_arrive_together: assert property (
    @(posedge clk) disable iff (reset)
    dc_val_i == nyq_val_i
  );

  no_capture_while_held: assert property (
    @(posedge clk) disable iff (reset)
    capture |-> !link.res_val
  );

endmodule

`default_nettype wire

// ==== window_bins_top.sv ====
// Top level of the window bin accelerator with plain Wishbone ports
// Wires the bus bridge, both accumulators and the combiner
`default_nettype none

module window_bins_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                wbs_stb_i,
  input  logic                wbs_cyc_i,
  input  logic                wbs_we_i,
  // Byte selects are ignored, full-word accesses only
  input  logic [3:0]          wbs_sel_i,
  input  fft_bins_pkg::addr_t wbs_adr_i,
  input  fft_bins_pkg::word_t wbs_dat_i,
  output logic                wbs_ack_o,
  output fft_bins_pkg::word_t wbs_dat_o
);

  accel_link_if link ();

  logic               dc_val;
  fft_bins_pkg::acc_t dc_sum;
  logic               nyq_val;
  fft_bins_pkg::acc_t nyq_sum;

  // ----------------------------------------
  // Bus side
  // ----------------------------------------
  wb_stream_bridge u_bridge (
    .clk       (clk),
    .reset     (reset),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o),
    .link      (link.bridge)
  );

  // ----------------------------------------
  // Bin engine
  // ----------------------------------------
  dc_window_accum u_dc (
    .clk      (clk),
    .reset    (reset),
    .link     (link.accum),
    .dc_val_o (dc_val),
    .dc_sum_o (dc_sum)
  );

  nyquist_window_accum u_nyq (
    .clk       (clk),
    .reset     (reset),
    .link      (link.accum),
    .nyq_val_o (nyq_val),
    .nyq_sum_o (nyq_sum)
  );

  bin_combiner u_comb (
    .clk       (clk),
    .reset     (reset),
    .dc_val_i  (dc_val),
    .dc_sum_i  (dc_sum),
    .nyq_val_i (nyq_val),
    .nyq_sum_i (nyq_sum),
    .link      (link.combiner)
  );

endmodule

`default_nettype wire

// ==== tb_window_bins.sv ====
// Testbench for the window bin accelerator
// Drives Wishbone accesses and checks bin words against a sliding-window model
`default_nettype none

module tb_window_bins;

  // About 250 sample pairs at roughly 7 cycles each, plus loopback traffic
  localparam int MAX_CYCLES = 5000;

  logic                clk;
  logic                reset;
  logic                wbs_stb;
  logic                wbs_cyc;
  logic                wbs_we;
  logic [3:0]          wbs_sel;
  fft_bins_pkg::addr_t wbs_adr;
  fft_bins_pkg::word_t wbs_dat_w;
  logic                wbs_ack;
  fft_bins_pkg::word_t wbs_dat_r;

  // Model history, entry 0 is the newest sample
  int hist [8];
  int cycles;

  window_bins_top dut (
    .clk       (clk),
    .reset     (reset),
    .wbs_stb_i (wbs_stb),
    .wbs_cyc_i (wbs_cyc),
    .wbs_we_i  (wbs_we),
    .wbs_sel_i (wbs_sel),
    .wbs_adr_i (wbs_adr),
    .wbs_dat_i (wbs_dat_w),
    .wbs_ack_o (wbs_ack),
    .wbs_dat_o (wbs_dat_r)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ----------------------------------------
  // Checks and reference model
  // ----------------------------------------
  task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (expected !== actual) begin
      $display("MISMATCH at time %0t: %s expected %h got %h", $time, what, expected, actual);
      $display("TB FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  function automatic void push_sample(input int smp);
    for (int i = 7; i > 0; i--) begin
      hist[i] = hist[i-1];
    end
    hist[0] = smp;
  endfunction

  // Division by eight that rounds toward minus infinity
  function automatic int floor_div8(input int s);
    int q;
    q = s / 8;
    if ((s % 8 != 0) && (s < 0)) begin
      q = q - 1;
    end
    return q;
  endfunction

  function automatic fft_bins_pkg::word_t expected_bins();
    int dc_sum;
    int nyq_sum;
    int dc_q;
    int nyq_q;
    dc_sum  = 0;
    nyq_sum = 0;
    for (int i = 0; i < 8; i++) begin
      dc_sum = dc_sum + hist[i];
      // Newest sample positive, then alternating
      if (i % 2 == 0) begin
        nyq_sum = nyq_sum + hist[i];
      end else begin
        nyq_sum = nyq_sum - hist[i];
      end
    end
    dc_q  = floor_div8(dc_sum);
    nyq_q = floor_div8(nyq_sum);
    return {dc_q[15:0], nyq_q[15:0]};
  endfunction

  // ----------------------------------------
  // Bus tasks
  // ----------------------------------------
  task automatic bus_access(input logic we, input fft_bins_pkg::addr_t adr,
                            input fft_bins_pkg::word_t dat,
                            output fft_bins_pkg::word_t rdata);
    @(posedge clk);
    wbs_stb   <= 1'b1;
    wbs_cyc   <= 1'b1;
    wbs_we    <= we;
    wbs_adr   <= adr;
    wbs_dat_w <= dat;
    // Ack and read data are sampled mid-cycle
    do begin
      @(negedge clk);
    end while (!wbs_ack);
    rdata = wbs_dat_r;
    @(posedge clk);
    wbs_stb <= 1'b0;
    wbs_cyc <= 1'b0;
    wbs_we  <= 1'b0;
  endtask

  task automatic wb_write(input fft_bins_pkg::addr_t adr, input fft_bins_pkg::word_t dat);
    fft_bins_pkg::word_t ignored;
    bus_access(1'b1, adr, dat, ignored);
  endtask

  task automatic wb_read(input fft_bins_pkg::addr_t adr, output fft_bins_pkg::word_t dat);
    bus_access(1'b0, adr, 32'd0, dat);
  endtask

  // One sample write followed by the bin read
  task automatic sample_roundtrip(input fft_bins_pkg::word_t w);
    fft_bins_pkg::sample_t smp;
    fft_bins_pkg::word_t   exp_w;
    fft_bins_pkg::word_t   rdata;
    smp = w[15:0];
    push_sample(int'(smp));
    exp_w = expected_bins();
    wb_write(fft_bins_pkg::BIN_ADDR, w);
    wb_read(fft_bins_pkg::BIN_ADDR, rdata);
    check_equal(exp_w, rdata, "bin word");
  endtask

  task automatic loopback_roundtrip(input fft_bins_pkg::word_t w);
    fft_bins_pkg::word_t rdata;
    wb_write(fft_bins_pkg::BASE_ADDR, w);
    wb_read(fft_bins_pkg::BASE_ADDR, rdata);
    check_equal(w, rdata, "loopback word");
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    reset     = 1'b1;
    wbs_stb   = 1'b0;
    wbs_cyc   = 1'b0;
    wbs_we    = 1'b0;
    wbs_sel   = 4'hf;
    wbs_adr   = '0;
    wbs_dat_w = '0;
    cycles    = 0;
    for (int i = 0; i < 8; i++) begin
      hist[i] = 0;
    end
    void'($urandom(66));
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Idle bus after reset, then a window with a single sample
    @(negedge clk);
    check_equal(32'd0, {31'b0, wbs_ack}, "ack after reset");
    sample_roundtrip(32'h0000_1234);

    for (int i = 0; i < 20; i++) begin
      loopback_roundtrip($urandom());
    end

    // Random samples, upper half of the word is junk
    for (int i = 0; i < 200; i++) begin
      sample_roundtrip($urandom());
    end

    // Extremes of the sample range
    for (int i = 0; i < 8; i++) begin
      sample_roundtrip(32'h0000_8000);
    end
    for (int i = 0; i < 16; i++) begin
      sample_roundtrip((i % 2 == 0) ? 32'h0000_7fff : 32'h0000_8001);
    end

    // Loopback traffic between sample pairs
    for (int i = 0; i < 12; i++) begin
      sample_roundtrip($urandom());
      loopback_roundtrip($urandom());
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
fft_bins_pkg.sv
accel_link_if.sv
wb_stream_bridge.sv
dc_window_accum.sv
nyquist_window_accum.sv
bin_combiner.sv
window_bins_top.sv
tb_window_bins.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_window_bins

.PHONY: all run clean

all: run

$(SIM): flist.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module tb_window_bins -f flist.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
